//--- source/rs_params.svh
`ifndef RS_PARAMS_SVH
`define RS_PARAMS_SVH

// Scheduler sizing
// Each slot index has a fixed role
`define RS_SZ 5

// Physical register tag width
// Tag 0 stands for no register and never wakes anything up
`define TAG_W 6

// Execution unit depths in cycles from issue edge to result
`define MEM_LAT 2
`define MUL_LAT 3

`endif

//--- source/isa_pkg.sv
package isa_pkg;

	// Operation codes as seen by the scheduler
	typedef enum logic [3:0] {
		ADD    = 4'd0,
		SUB    = 4'd1,
		AND    = 4'd2,
		OR     = 4'd3,
		XOR    = 4'd4,
		SLT    = 4'd5,
		MUL    = 4'd6,
		MULH   = 4'd7,
		MULHSU = 4'd8,
		MULHU  = 4'd9,
		LOAD   = 4'd10,
		STORE  = 4'd11
	} alu_func_t;

	// Execution unit that owns an operation
	typedef enum logic [1:0] {
		FU_ALU = 2'd0,
		FU_MEM = 2'd1,
		FU_MUL = 2'd2
	} fu_class_t;

	function automatic fu_class_t func_class(alu_func_t func);
		case (func)
			MUL, MULH, MULHSU, MULHU: return FU_MUL;
			LOAD, STORE:              return FU_MEM;
			default:                  return FU_ALU;
		endcase
	endfunction

	// Multiplies that return the upper half of the product
	function automatic logic is_high_mul(alu_func_t func);
		return func inside {MULH, MULHSU, MULHU};
	endfunction

endpackage

//--- source/rs_pkg.sv
`include "rs_params.svh"

package rs_pkg;

	typedef logic [`TAG_W-1:0] tag_t;

	typedef logic [$clog2(`RS_SZ)-1:0] slot_idx_t;

	// The operation reads a source marked valid
	// A ready source already has its value
	typedef struct packed {
		tag_t tag;
		logic valid;
		logic ready;
	} operand_t;

	typedef struct packed {
		logic                busy;
		logic                issued;
		isa_pkg::alu_func_t  func;
		tag_t                dest;
		operand_t            src1;
		operand_t            src2;
	} rs_entry_t;

	// Fixed slot roles
	localparam slot_idx_t SLOT_MUL   = 3'd0;
	localparam slot_idx_t SLOT_LOAD  = 3'd1;
	localparam slot_idx_t SLOT_STORE = 3'd2;
	localparam slot_idx_t SLOT_ALU0  = 3'd3;
	localparam slot_idx_t SLOT_ALU1  = 3'd4;

endpackage

//--- source/latency_pipe.sv
module latency_pipe #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 2
) (
	input  logic     clock,
	input  logic     reset,
	input  logic     flush,
	input  logic     in_valid,
	input  payload_t in_data,
	input  logic     hold,
	output logic     out_valid,
	output payload_t out_data,
	output logic     full
);

	logic     stage_valid [DEPTH];
	payload_t stage_data  [DEPTH];
	logic     stage_take  [DEPTH];

	// A stage loads when it is empty or its contents move on
	always_comb begin
		stage_take[DEPTH-1] = !hold;
		for (int i = DEPTH - 2; i >= 0; i--) begin
			stage_take[i] = !stage_valid[i] || stage_take[i+1];
		end
	end

	always_ff @(posedge clock) begin
		if (reset || flush) begin
			for (int i = 0; i < DEPTH; i++) begin
				stage_valid[i] <= 1'b0;
			end
		end else begin
			if (stage_take[0]) begin
				stage_valid[0] <= in_valid;
			end
			for (int i = 1; i < DEPTH; i++) begin
				if (stage_take[i]) begin
					stage_valid[i] <= stage_valid[i-1];
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (stage_take[0]) begin
			stage_data[0] <= in_data;
		end
		for (int i = 1; i < DEPTH; i++) begin
			if (stage_take[i]) begin
				stage_data[i] <= stage_data[i-1];
			end
		end
	end

	assign out_valid = stage_valid[DEPTH-1];
	assign out_data  = stage_data[DEPTH-1];
	assign full      = !stage_take[0];

endmodule

//--- source/reservation_station.sv
`include "rs_params.svh"

module reservation_station (
	input  logic               clock,
	input  logic               reset,
	input  logic               interrupt,

	input  logic               dispatch_valid,
	input  isa_pkg::alu_func_t dispatch_func,
	input  rs_pkg::tag_t       dispatch_dest,
	input  rs_pkg::tag_t       dispatch_src1_tag,
	input  logic               dispatch_src1_valid,
	input  logic               dispatch_src1_ready,
	input  rs_pkg::tag_t       dispatch_src2_tag,
	input  logic               dispatch_src2_valid,
	input  logic               dispatch_src2_ready,
	output logic               dispatch_ready,

	input  logic               cdb_valid,
	input  rs_pkg::tag_t       cdb_tag,

	output logic               issue_valid,
	output isa_pkg::alu_func_t issue_func,
	output rs_pkg::tag_t       issue_dest,
	output rs_pkg::slot_idx_t  issue_slot,
	input  logic               issue_stall,

	input  logic               remove_valid,
	input  rs_pkg::slot_idx_t  remove_slot
);

	rs_pkg::rs_entry_t rs_table [`RS_SZ];
	rs_pkg::rs_entry_t new_entry;
	rs_pkg::slot_idx_t dispatch_slot;

	function automatic logic cdb_match(rs_pkg::tag_t tag, logic bus_valid, rs_pkg::tag_t bus_tag);
		return bus_valid && tag != '0 && tag == bus_tag;
	endfunction

	function automatic logic operand_ok(rs_pkg::operand_t op);
		return !op.valid || op.ready;
	endfunction

	// Stores, loads and multiplies own one slot each while ALU ops share two
	always_comb begin
		case (isa_pkg::func_class(dispatch_func))
			isa_pkg::FU_MUL: dispatch_slot = rs_pkg::SLOT_MUL;
			isa_pkg::FU_MEM: begin
				dispatch_slot = (dispatch_func == isa_pkg::STORE) ? rs_pkg::SLOT_STORE
				                                                   : rs_pkg::SLOT_LOAD;
			end
			default: begin
				dispatch_slot = rs_table[rs_pkg::SLOT_ALU0].busy ? rs_pkg::SLOT_ALU1
				                                                 : rs_pkg::SLOT_ALU0;
			end
		endcase
	end

	assign dispatch_ready = !rs_table[dispatch_slot].busy;

	// Incoming sources also catch a broadcast in the same cycle
	always_comb begin
		new_entry.busy        = 1'b1;
		new_entry.issued      = 1'b0;
		new_entry.func        = dispatch_func;
		new_entry.dest        = dispatch_dest;
		new_entry.src1.tag    = dispatch_src1_tag;
		new_entry.src1.valid  = dispatch_src1_valid;
		new_entry.src1.ready  = dispatch_src1_ready ||
		                        cdb_match(dispatch_src1_tag, cdb_valid, cdb_tag);
		new_entry.src2.tag    = dispatch_src2_tag;
		new_entry.src2.valid  = dispatch_src2_valid;
		new_entry.src2.ready  = dispatch_src2_ready ||
		                        cdb_match(dispatch_src2_tag, cdb_valid, cdb_tag);
	end

	// Highest ready index wins
	always_comb begin
		issue_valid = 1'b0;
		issue_slot  = '0;
		for (int i = 0; i < `RS_SZ; i++) begin
			if (rs_table[i].busy && !rs_table[i].issued &&
			    operand_ok(rs_table[i].src1) && operand_ok(rs_table[i].src2)) begin
				issue_valid = 1'b1;
				issue_slot  = rs_pkg::slot_idx_t'(i);
			end
		end
	end

	assign issue_func = rs_table[issue_slot].func;
	assign issue_dest = rs_table[issue_slot].dest;

	always_ff @(posedge clock) begin
		if (reset || interrupt) begin
			for (int i = 0; i < `RS_SZ; i++) begin
				rs_table[i].busy   <= 1'b0;
				rs_table[i].issued <= 1'b0;
			end
		end else begin
			// Wakeup
			for (int i = 0; i < `RS_SZ; i++) begin
				if (cdb_match(rs_table[i].src1.tag, cdb_valid, cdb_tag)) begin
					rs_table[i].src1.ready <= 1'b1;
				end
				if (cdb_match(rs_table[i].src2.tag, cdb_valid, cdb_tag)) begin
					rs_table[i].src2.ready <= 1'b1;
				end
			end

			if (issue_valid && !issue_stall) begin
				rs_table[issue_slot].issued <= 1'b1;
			end

			if (dispatch_valid && dispatch_ready) begin
				rs_table[dispatch_slot] <= new_entry;
			end

			if (remove_valid) begin
				rs_table[remove_slot].busy   <= 1'b0;
				rs_table[remove_slot].issued <= 1'b0;
			end
		end
	end

	// An accepted operation lands in a free slot and waits there unissued
	assert property (@(posedge clock) disable iff (reset || interrupt)
		dispatch_valid && dispatch_ready |=>
		rs_table[$past(dispatch_slot)].busy && !rs_table[$past(dispatch_slot)].issued);

	// Completions only come back for entries that were handed to a unit
	assert property (@(posedge clock) disable iff (reset)
		remove_valid |-> rs_table[remove_slot].busy && rs_table[remove_slot].issued);

endmodule

//--- source/exec_units.sv
`include "rs_params.svh"

module exec_units (
	input  logic               clock,
	input  logic               reset,
	input  logic               interrupt,

	input  logic               issue_valid,
	input  isa_pkg::alu_func_t issue_func,
	input  rs_pkg::tag_t       issue_dest,
	input  rs_pkg::slot_idx_t  issue_slot,
	output logic               issue_stall,

	input  logic               grant_alu,
	input  logic               grant_mem,
	input  logic               grant_mul,

	output logic               done_valid_alu,
	output logic               done_valid_mem,
	output logic               done_valid_mul,
	output rs_pkg::tag_t       done_dest_alu,
	output rs_pkg::tag_t       done_dest_mem,
	output rs_pkg::tag_t       done_dest_mul,
	output rs_pkg::slot_idx_t  done_slot_alu,
	output rs_pkg::slot_idx_t  done_slot_mem,
	output rs_pkg::slot_idx_t  done_slot_mul,
	output logic               done_store
);

	typedef struct packed {
		rs_pkg::tag_t      dest;
		rs_pkg::slot_idx_t slot;
	} mem_op_t;

	// Upper-half select rides along for the product datapath
	typedef struct packed {
		rs_pkg::tag_t      dest;
		rs_pkg::slot_idx_t slot;
		logic              high;
	} mul_op_t;

	isa_pkg::fu_class_t issue_class;
	logic               alu_hold;
	logic               mem_hold;
	logic               mul_hold;
	logic               mem_full;
	logic               mul_full;
	mem_op_t            mem_in;
	mem_op_t            mem_out;
	mul_op_t            mul_in;
	mul_op_t            mul_out;

	assign issue_class = isa_pkg::func_class(issue_func);

	// A finished result sits until the CDB takes it
	assign alu_hold = done_valid_alu && !grant_alu;
	assign mem_hold = done_valid_mem && !grant_mem;
	assign mul_hold = done_valid_mul && !grant_mul;

	always_comb begin
		case (issue_class)
			isa_pkg::FU_MEM: issue_stall = mem_full;
			isa_pkg::FU_MUL: issue_stall = mul_full;
			default:         issue_stall = alu_hold;
		endcase
	end

	// Single-cycle ALU
	always_ff @(posedge clock) begin
		if (reset || interrupt) begin
			done_valid_alu <= 1'b0;
		end else if (!alu_hold) begin
			done_valid_alu <= issue_valid && issue_class == isa_pkg::FU_ALU;
		end
	end

	always_ff @(posedge clock) begin
		if (!alu_hold) begin
			done_dest_alu <= issue_dest;
			done_slot_alu <= issue_slot;
		end
	end

	assign mem_in.dest = issue_dest;
	assign mem_in.slot = issue_slot;

	latency_pipe #(
		.payload_t (mem_op_t),
		.DEPTH     (`MEM_LAT)
	) mem_pipe (
		.clock     (clock),
		.reset     (reset),
		.flush     (interrupt),
		.in_valid  (issue_valid && issue_class == isa_pkg::FU_MEM),
		.in_data   (mem_in),
		.hold      (mem_hold),
		.out_valid (done_valid_mem),
		.out_data  (mem_out),
		.full      (mem_full)
	);

	assign done_dest_mem = mem_out.dest;
	assign done_slot_mem = mem_out.slot;
	assign done_store    = mem_out.slot == rs_pkg::SLOT_STORE;

	assign mul_in.dest = issue_dest;
	assign mul_in.slot = issue_slot;
	assign mul_in.high = isa_pkg::is_high_mul(issue_func);

	latency_pipe #(
		.payload_t (mul_op_t),
		.DEPTH     (`MUL_LAT)
	) mul_pipe (
		.clock     (clock),
		.reset     (reset),
		.flush     (interrupt),
		.in_valid  (issue_valid && issue_class == isa_pkg::FU_MUL),
		.in_data   (mul_in),
		.hold      (mul_hold),
		.out_valid (done_valid_mul),
		.out_data  (mul_out),
		.full      (mul_full)
	);

	assign done_dest_mul = mul_out.dest;
	assign done_slot_mul = mul_out.slot;

endmodule

//--- source/cdb_arbiter.sv
module cdb_arbiter (
	input  logic              done_valid_alu,
	input  logic              done_valid_mem,
	input  logic              done_valid_mul,
	input  rs_pkg::tag_t      done_dest_alu,
	input  rs_pkg::tag_t      done_dest_mem,
	input  rs_pkg::tag_t      done_dest_mul,
	input  rs_pkg::slot_idx_t done_slot_alu,
	input  rs_pkg::slot_idx_t done_slot_mem,
	input  rs_pkg::slot_idx_t done_slot_mul,
	input  logic              done_store,

	output logic              grant_alu,
	output logic              grant_mem,
	output logic              grant_mul,
	output logic              cdb_valid,
	output rs_pkg::tag_t      cdb_tag,
	output logic              remove_valid,
	output rs_pkg::slot_idx_t remove_slot
);

	// Longest pipe drains first
	always_comb begin
		grant_mul = done_valid_mul;
		grant_mem = done_valid_mem && !done_valid_mul;
		grant_alu = done_valid_alu && !done_valid_mem && !done_valid_mul;
		assert ($onehot0({grant_alu, grant_mem, grant_mul}));
	end

	always_comb begin
		remove_valid = 1'b1;
		if (grant_mul) begin
			cdb_tag     = done_dest_mul;
			remove_slot = done_slot_mul;
		end else if (grant_mem) begin
			cdb_tag     = done_dest_mem;
			remove_slot = done_slot_mem;
		end else if (grant_alu) begin
			cdb_tag     = done_dest_alu;
			remove_slot = done_slot_alu;
		end else begin
			remove_valid = 1'b0;
			cdb_tag      = '0;
			remove_slot  = '0;
		end
	end

	// Stores free their slot without a broadcast
	assign cdb_valid = remove_valid && !(grant_mem && done_store);

endmodule

//--- source/rs_core.sv
module rs_core (
	input  logic               clock,
	input  logic               reset,
	input  logic               interrupt,

	input  logic               dispatch_valid,
	input  isa_pkg::alu_func_t dispatch_func,
	input  rs_pkg::tag_t       dispatch_dest,
	input  rs_pkg::tag_t       dispatch_src1_tag,
	input  logic               dispatch_src1_valid,
	input  logic               dispatch_src1_ready,
	input  rs_pkg::tag_t       dispatch_src2_tag,
	input  logic               dispatch_src2_valid,
	input  logic               dispatch_src2_ready,
	output logic               dispatch_ready,

	output logic               cdb_valid,
	output rs_pkg::tag_t       cdb_tag
);

	logic               issue_valid;
	isa_pkg::alu_func_t issue_func;
	rs_pkg::tag_t       issue_dest;
	rs_pkg::slot_idx_t  issue_slot;
	logic               issue_stall;

	logic               grant_alu;
	logic               grant_mem;
	logic               grant_mul;
	logic               done_valid_alu;
	logic               done_valid_mem;
	logic               done_valid_mul;
	rs_pkg::tag_t       done_dest_alu;
	rs_pkg::tag_t       done_dest_mem;
	rs_pkg::tag_t       done_dest_mul;
	rs_pkg::slot_idx_t  done_slot_alu;
	rs_pkg::slot_idx_t  done_slot_mem;
	rs_pkg::slot_idx_t  done_slot_mul;
	logic               done_store;

	logic               remove_valid;
	rs_pkg::slot_idx_t  remove_slot;

	reservation_station reservation_station_inst (
		.clock               (clock),
		.reset               (reset),
		.interrupt           (interrupt),
		.dispatch_valid      (dispatch_valid),
		.dispatch_func       (dispatch_func),
		.dispatch_dest       (dispatch_dest),
		.dispatch_src1_tag   (dispatch_src1_tag),
		.dispatch_src1_valid (dispatch_src1_valid),
		.dispatch_src1_ready (dispatch_src1_ready),
		.dispatch_src2_tag   (dispatch_src2_tag),
		.dispatch_src2_valid (dispatch_src2_valid),
		.dispatch_src2_ready (dispatch_src2_ready),
		.dispatch_ready      (dispatch_ready),
		.cdb_valid           (cdb_valid),
		.cdb_tag             (cdb_tag),
		.issue_valid         (issue_valid),
		.issue_func          (issue_func),
		.issue_dest          (issue_dest),
		.issue_slot          (issue_slot),
		.issue_stall         (issue_stall),
		.remove_valid        (remove_valid),
		.remove_slot         (remove_slot)
	);

	exec_units exec_units_inst (
		.clock          (clock),
		.reset          (reset),
		.interrupt      (interrupt),
		.issue_valid    (issue_valid),
		.issue_func     (issue_func),
		.issue_dest     (issue_dest),
		.issue_slot     (issue_slot),
		.issue_stall    (issue_stall),
		.grant_alu      (grant_alu),
		.grant_mem      (grant_mem),
		.grant_mul      (grant_mul),
		.done_valid_alu (done_valid_alu),
		.done_valid_mem (done_valid_mem),
		.done_valid_mul (done_valid_mul),
		.done_dest_alu  (done_dest_alu),
		.done_dest_mem  (done_dest_mem),
		.done_dest_mul  (done_dest_mul),
		.done_slot_alu  (done_slot_alu),
		.done_slot_mem  (done_slot_mem),
		.done_slot_mul  (done_slot_mul),
		.done_store     (done_store)
	);

	cdb_arbiter cdb_arbiter_inst (
		.done_valid_alu (done_valid_alu),
		.done_valid_mem (done_valid_mem),
		.done_valid_mul (done_valid_mul),
		.done_dest_alu  (done_dest_alu),
		.done_dest_mem  (done_dest_mem),
		.done_dest_mul  (done_dest_mul),
		.done_slot_alu  (done_slot_alu),
		.done_slot_mem  (done_slot_mem),
		.done_slot_mul  (done_slot_mul),
		.done_store     (done_store),
		.grant_alu      (grant_alu),
		.grant_mem      (grant_mem),
		.grant_mul      (grant_mul),
		.cdb_valid      (cdb_valid),
		.cdb_tag        (cdb_tag),
		.remove_valid   (remove_valid),
		.remove_slot    (remove_slot)
	);

endmodule

//--- tests/rs_core_tb.sv
`include "rs_params.svh"

module rs_core_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_TAGS = 1 << `TAG_W;

	typedef struct {
		string name;
		string func;
		int    dest;
		int    src1_tag;
		int    src1_valid;
		int    src1_ready;
		int    src2_tag;
		int    src2_valid;
		int    src2_ready;
		int    idle;
		int    accept;
	} test_line_t;

	logic               clock;
	logic               reset;
	logic               interrupt;
	logic               dispatch_valid;
	isa_pkg::alu_func_t dispatch_func;
	rs_pkg::tag_t       dispatch_dest;
	rs_pkg::tag_t       dispatch_src1_tag;
	logic               dispatch_src1_valid;
	logic               dispatch_src1_ready;
	rs_pkg::tag_t       dispatch_src2_tag;
	logic               dispatch_src2_valid;
	logic               dispatch_src2_ready;
	logic               dispatch_ready;
	logic               cdb_valid;
	rs_pkg::tag_t       cdb_tag;

	test_line_t lines [$];
	bit         lines_loaded;

	// Scoreboard indexed by tag
	bit         pending    [NUM_TAGS];
	bit         killed     [NUM_TAGS];
	bit         seen       [NUM_TAGS];
	int         seen_cycle [NUM_TAGS];
	int         wait_src1  [NUM_TAGS];
	int         wait_src2  [NUM_TAGS];
	int         pending_count;

	int         cycle;
	int         error_count;
	int         tests_passed;
	int         tests_failed;
	string      current_test;
	integer     seed;

	rs_core rs_core_inst (
		.clock               (clock),
		.reset               (reset),
		.interrupt           (interrupt),
		.dispatch_valid      (dispatch_valid),
		.dispatch_func       (dispatch_func),
		.dispatch_dest       (dispatch_dest),
		.dispatch_src1_tag   (dispatch_src1_tag),
		.dispatch_src1_valid (dispatch_src1_valid),
		.dispatch_src1_ready (dispatch_src1_ready),
		.dispatch_src2_tag   (dispatch_src2_tag),
		.dispatch_src2_valid (dispatch_src2_valid),
		.dispatch_src2_ready (dispatch_src2_ready),
		.dispatch_ready      (dispatch_ready),
		.cdb_valid           (cdb_valid),
		.cdb_tag             (cdb_tag)
	);

	initial clock = 1'b0;
	always #5 clock = ~clock;

	always @(posedge clock) begin
		cycle <= cycle + 1;
	end

	task automatic check_value(string what, int expected, int actual);
		if (expected != actual) begin
			error_count++;
			$display("Error in %s: %s expected %0d actual %0d",
			         current_test, what, expected, actual);
		end
	endtask

	function automatic isa_pkg::alu_func_t func_code(string name);
		case (name)
			"ADD":    return isa_pkg::ADD;
			"SUB":    return isa_pkg::SUB;
			"AND":    return isa_pkg::AND;
			"OR":     return isa_pkg::OR;
			"XOR":    return isa_pkg::XOR;
			"SLT":    return isa_pkg::SLT;
			"MUL":    return isa_pkg::MUL;
			"MULH":   return isa_pkg::MULH;
			"MULHSU": return isa_pkg::MULHSU;
			"MULHU":  return isa_pkg::MULHU;
			"LOAD":   return isa_pkg::LOAD;
			"STORE":  return isa_pkg::STORE;
			default: begin
				$display("Unknown function %s in the test file", name);
				error_count++;
				return isa_pkg::ADD;
			end
		endcase
	endfunction

	function automatic bit is_burst_test(string name);
		for (int k = 0; k + 5 <= name.len(); k++) begin
			if (name.substr(k, k + 4) == "burst") begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	task automatic load_tests();
		int         fd;
		int         code;
		int         ch;
		string      word;
		test_line_t ln;
		fd = $fopen("tests/rs_core_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open tests/rs_core_tests.txt");
			error_count++;
			return;
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", word);
			if (code != 1) begin
				break;
			end
			if (word.substr(0, 0) == "#") begin
				// Skip the rest of a comment line
				ch = $fgetc(fd);
				while (ch != 10 && ch != -1) begin
					ch = $fgetc(fd);
				end
				continue;
			end
			ln.name = word;
			code = $fscanf(fd, "%s %d %d %d %d %d %d %d %d %d", ln.func, ln.dest,
			               ln.src1_tag, ln.src1_valid, ln.src1_ready,
			               ln.src2_tag, ln.src2_valid, ln.src2_ready, ln.idle, ln.accept);
			if (code != 10) begin
				$display("Malformed line for test %s in the test file", word);
				error_count++;
				break;
			end
			lines.push_back(ln);
		end
		$fclose(fd);
	endtask

	task automatic check_order(int tag, int src);
		if (src != 0) begin
			check_value($sformatf("source %0d on CDB before tag %0d", src, tag), 1,
			            int'(seen[src] && seen_cycle[src] < cycle));
		end
	endtask

	task automatic note_broadcast(int tag);
		if (killed[tag]) begin
			check_value($sformatf("broadcasts of flushed tag %0d", tag), 0, 1);
		end else begin
			check_value($sformatf("tag %0d awaited on CDB", tag), 1, int'(pending[tag]));
		end
		if (pending[tag]) begin
			check_order(tag, wait_src1[tag]);
			check_order(tag, wait_src2[tag]);
			pending[tag] = 1'b0;
			pending_count--;
		end
		seen[tag]       = 1'b1;
		seen_cycle[tag] = cycle;
	endtask

	task automatic note_dispatch(test_line_t ln);
		// Stores free their slot silently
		if (ln.func != "STORE") begin
			pending[ln.dest] = 1'b1;
			pending_count++;
		end
		wait_src1[ln.dest] = (ln.src1_valid != 0 && ln.src1_ready == 0) ? ln.src1_tag : 0;
		wait_src2[ln.dest] = (ln.src2_valid != 0 && ln.src2_ready == 0) ? ln.src2_tag : 0;
	endtask

	// CDB sampled mid-cycle where it is stable
	always @(negedge clock) begin
		if (!reset && cdb_valid) begin
			note_broadcast(int'(cdb_tag));
		end
	end

	task automatic flush_and_sweep();
		isa_pkg::alu_func_t f;
		@(posedge clock);
		interrupt      <= 1'b1;
		dispatch_valid <= 1'b0;
		@(posedge clock);
		interrupt <= 1'b0;
		// Anything still in flight is gone for good
		for (int t = 0; t < NUM_TAGS; t++) begin
			if (pending[t]) begin
				killed[t]  = 1'b1;
				pending[t] = 1'b0;
			end
		end
		pending_count = 0;
		f = f.first();
		for (int i = 0; i < f.num(); i++) begin
			if (i > 0) begin
				@(posedge clock);
			end
			dispatch_func <= f;
			@(negedge clock);
			check_value($sformatf("dispatch_ready for %s after flush", f.name()), 1,
			            int'(dispatch_ready));
			f = f.next();
		end
	endtask

	task automatic run_line(test_line_t ln);
		if (ln.func == "FLUSH") begin
			flush_and_sweep();
		end else begin
			@(posedge clock);
			dispatch_valid      <= 1'b1;
			dispatch_func       <= func_code(ln.func);
			dispatch_dest       <= rs_pkg::tag_t'(ln.dest);
			dispatch_src1_tag   <= rs_pkg::tag_t'(ln.src1_tag);
			dispatch_src1_valid <= ln.src1_valid != 0;
			dispatch_src1_ready <= ln.src1_ready != 0;
			dispatch_src2_tag   <= rs_pkg::tag_t'(ln.src2_tag);
			dispatch_src2_valid <= ln.src2_valid != 0;
			dispatch_src2_ready <= ln.src2_ready != 0;
			@(negedge clock);
			check_value($sformatf("dispatch_ready for tag %0d", ln.dest), ln.accept,
			            int'(dispatch_ready));
			if (dispatch_ready) begin
				note_dispatch(ln);
			end
		end
		repeat (ln.idle) begin
			@(posedge clock);
			dispatch_valid <= 1'b0;
		end
	endtask

	task automatic finish_test(int first_error);
		if (error_count == first_error) begin
			tests_passed++;
			$display("Test %s: passed", current_test);
		end else begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", current_test, error_count - first_error);
		end
	endtask

	initial begin
		int idx;
		int first_error;
		int gap;
		reset               = 1'b1;
		interrupt           = 1'b0;
		dispatch_valid      = 1'b0;
		dispatch_func       = isa_pkg::ADD;
		dispatch_dest       = '0;
		dispatch_src1_tag   = '0;
		dispatch_src1_valid = 1'b0;
		dispatch_src1_ready = 1'b0;
		dispatch_src2_tag   = '0;
		dispatch_src2_valid = 1'b0;
		dispatch_src2_ready = 1'b0;
		cycle               = 0;
		error_count         = 0;
		tests_passed        = 0;
		tests_failed        = 0;
		pending_count       = 0;
		current_test        = "setup";
		seed                = 32'h765b;
		for (int t = 0; t < NUM_TAGS; t++) begin
			pending[t]    = 1'b0;
			killed[t]     = 1'b0;
			seen[t]       = 1'b0;
			seen_cycle[t] = 0;
			wait_src1[t]  = 0;
			wait_src2[t]  = 0;
		end
		load_tests();
		lines_loaded = 1'b1;

		repeat (3) @(posedge clock);
		reset <= 1'b0;

		idx = 0;
		while (idx < lines.size()) begin
			current_test = lines[idx].name;
			first_error  = error_count;
			if (is_burst_test(current_test)) begin
				gap = $random(seed) & 3;
				repeat (gap) @(posedge clock);
			end
			while (idx < lines.size() && lines[idx].name == current_test) begin
				run_line(lines[idx]);
				idx++;
			end
			@(posedge clock);
			dispatch_valid <= 1'b0;
			while (pending_count != 0) begin
				@(posedge clock);
			end
			// Late duplicates and store removals settle here
			repeat (8) @(posedge clock);
			finish_test(first_error);
		end

		$display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
		if (tests_failed == 0 && error_count == 0 && lines.size() > 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial begin
		wait (lines_loaded);
		repeat (lines.size() * 40 + 100) @(posedge clock);
		$display("Timeout: the run did not finish within %0d cycles", lines.size() * 40 + 100);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- rs_core.f
+incdir+source
source/isa_pkg.sv
source/rs_pkg.sv
source/latency_pipe.sv
source/reservation_station.sv
source/exec_units.sv
source/cdb_arbiter.sv
source/rs_core.sv
tests/rs_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the rs_core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--timescale 1ns/100ps \
	-f rs_core.f \
	--top-module rs_core_tb \
	-o rs_core_sim

# The log decides the result, so a failing run must still reach the search below
./obj_dir/rs_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

//--- tests/rs_core_tests.txt
# name func dest src1_tag src1_valid src1_ready src2_tag src2_valid src2_ready idle accept
# Tags are unique over the file, FLUSH pulses interrupt and sweeps every function
mul_busy     MUL     1   0 0 0    0 0 0   0 1
mul_busy     MULHU   2   0 0 0    0 0 0   4 0
mul_busy     MULH    3   1 1 1    0 0 0   0 1
alu_full     MUL     7   0 0 0    0 0 0   0 1
alu_full     ADD     8   7 1 0    0 0 0   0 1
alu_full     SUB     9   7 1 0    8 1 0   0 1
alu_full     OR     10   0 0 0    0 0 0   0 0
store_quiet  STORE  11   1 1 1    3 1 1   0 1
store_quiet  STORE  14   0 0 0    0 0 0   0 0
store_quiet  LOAD   13   0 0 0    0 0 0   0 1
same_cycle   ADD    15   0 0 0    0 0 0   1 1
same_cycle   LOAD   16  15 1 0    0 0 0   0 1
chain        MUL    17   0 0 0    0 0 0   0 1
chain        ADD    18  17 1 0    0 0 0   0 1
chain        LOAD   19  18 1 0   17 1 0   0 1
chain        STORE  35  19 1 0   18 1 0   0 1
burst_mix    MUL    20   0 0 0    0 0 0   0 1
burst_mix    LOAD   21   0 0 0    0 0 0   0 1
burst_mix    XOR    22   0 0 0    0 0 0   0 1
burst_pair   MULHSU 23   0 0 0    0 0 0   0 1
burst_pair   LOAD   24   0 0 0    0 0 0   0 1
burst_pair   ADD    25   0 0 0    0 0 0   0 1
burst_pair   SLT    26   0 0 0    0 0 0   0 1
flush        MUL    27   0 0 0    0 0 0   0 1
flush        ADD    28  27 1 0    0 0 0   0 1
flush        FLUSH   0   0 0 0    0 0 0   2 1
after_flush  MUL    30   0 0 0    0 0 0   0 1
after_flush  LOAD   31   0 0 0    0 0 0   0 1
after_flush  STORE  32  30 1 0    0 0 0   0 1
after_flush  ADD    33  31 1 0    0 0 0   0 1
after_flush  SUB    34   0 0 0    0 0 0   0 1
